//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  -f src.f \
  --top-module alu_exec_tb \
  --Mdir obj_dir \
  -o alu_exec_sim

./obj_dir/alu_exec_sim > sim.log 2>&1
cat sim.log

if grep -q "TEST PASS" sim.log; then
  exit 0
else
  exit 1
fi

//--- src.f
verilog/alu_pkg.sv
verilog/alu_uop_if.sv
verilog/insn_decoder.sv
verilog/uop_fifo.sv
verilog/alu.sv
verilog/alu_exec_top.sv
testbench/alu_exec_sva.sv
testbench/alu_exec_tb.sv

//--- testbench/alu_exec_sva.sv
`timescale 1ns/1ps

module alu_exec_sva (
  input logic                          clk,
  input logic                          rst_n,
  input logic                          push,
  input logic                          pop,
  input logic [alu_pkg::UOP_CNT_W-1:0] count
);
  import alu_pkg::*;

  // Issuer must stop before the queue overflows
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> (count != UOP_CNT_W'(UOP_DEPTH)))
    else $error("push into a full micro-op queue");

  // ALU pops only a real entry
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> (count != '0))
    else $error("pop from an empty micro-op queue");

  a_count_range: assert property (@(posedge clk) disable iff (!rst_n)
    count <= UOP_CNT_W'(UOP_DEPTH))
    else $error("queue occupancy above its depth");

endmodule

bind uop_fifo alu_exec_sva u_sva (
  .clk   (clk),
  .rst_n (rst_n),
  .push  (push),
  .pop   (pop),
  .count (count)
);

//--- testbench/alu_exec_tb.sv
`timescale 1ns/1ps

module alu_exec_tb;
  import alu_pkg::*;

  localparam int MAX_REC = 64;
  // insn, rs1, rs2, hold, result, illegal
  localparam int WORDS = 6;

  logic            clk;
  logic            rst_n;
  logic            issue;
  insn_t           insn;
  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  logic            hold;
  logic            busy;
  logic            illegal;
  logic            result_valid;
  logic [XLEN-1:0] result;
  reg_idx_t        result_rd;
  logic            result_zero;

  logic [31:0] vec [MAX_REC*WORDS];
  int n_rec = 0;
  int hold_sum = 0;
  int limit = 0;
  int cyc = 0;
  int mism = 0;
  int other = 0;
  int hold_left = 0;
  int last_hold_cyc = -100;
  int idx = 0;
  logic ill_drv = 1'b0;
  logic ill_exp = 1'b0;

  // Expected queue occupancy and decoder register state
  int   q_cnt = 0;
  logic q_dec = 1'b0;

  // Scoreboard, one entry per legal issue
  logic [XLEN-1:0] exp_res [$];
  reg_idx_t        exp_rd [$];
  logic            exp_zero [$];
  int              exp_cyc [$];

  logic [XLEN-1:0] e_res;
  reg_idx_t        e_rd;
  logic            e_zero;
  int              e_cyc;

  alu_exec_top i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .issue        (issue),
    .insn         (insn),
    .rs1_val      (rs1_val),
    .rs2_val      (rs2_val),
    .busy         (busy),
    .illegal      (illegal),
    .hold         (hold),
    .result_valid (result_valid),
    .result       (result),
    .result_rd    (result_rd),
    .result_zero  (result_zero)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_result(input logic [XLEN-1:0] got_res, input reg_idx_t got_rd,
                              input logic got_zero, input logic [XLEN-1:0] want_res,
                              input reg_idx_t want_rd, input logic want_zero);
    if (got_res !== want_res || got_rd !== want_rd || got_zero !== want_zero) begin
      $display("Mismatch at %0t: result %h rd %0d zero %b, expected %h rd %0d zero %b",
               $time, got_res, got_rd, got_zero, want_res, want_rd, want_zero);
      mism++;
    end
  endtask

  task automatic check_illegal(input logic got, input logic want);
    if (got !== want) begin
      $display("Mismatch at %0t: illegal %b, expected %b", $time, got, want);
      mism++;
    end
  endtask

  task automatic check_busy(input logic got, input logic want);
    if (got !== want) begin
      $display("Mismatch at %0t: busy %b, expected %b", $time, got, want);
      mism++;
    end
  endtask

  task automatic check_latency(input int got, input int want);
    if (got != want) begin
      $display("Mismatch at %0t: issue to result took %0d cycles, expected %0d",
               $time, got, want);
      mism++;
    end
  endtask

  // Drive one record and log what it should produce
  task automatic issue_record(input int r);
    insn_t           w_insn;
    logic [XLEN-1:0] w_res;
    int              w_hold;
    logic            w_ill;
    w_insn = vec[r*WORDS];
    w_hold = int'(vec[r*WORDS+3]);
    w_res  = vec[r*WORDS+4];
    w_ill  = vec[r*WORDS+5][0];
    issue   <= 1'b1;
    insn    <= w_insn;
    rs1_val <= vec[r*WORDS+1];
    rs2_val <= vec[r*WORDS+2];
    ill_drv <= w_ill;
    if (!w_ill) begin
      // Only an idle pipeline has the fixed latency
      exp_cyc.push_back(exp_res.size() == 0 ? cyc + 1 : -1);
      exp_res.push_back(w_res);
      exp_rd.push_back(w_insn.r.rd);
      exp_zero.push_back(w_res == '0);
    end
    if (w_hold > 0) begin
      hold_left = w_hold;
    end
  endtask

  // Cycle count, illegal expectation and last stall seen by the DUT
  always @(posedge clk) begin
    cyc     <= cyc + 1;
    ill_exp <= issue & ill_drv;
    if (hold) begin
      last_hold_cyc <= cyc + 1;
    end
  end

  // Legal issue lands in the queue one edge later, a stall-free head leaves
  always @(posedge clk) begin
    q_dec <= issue & ~ill_drv;
    q_cnt <= q_cnt + (q_dec ? 1 : 0) - ((q_cnt > 0 && !hold) ? 1 : 0);
  end

  always @(posedge clk) begin
    if (limit > 0 && cyc > limit) begin
      $display("Run stopped by timeout after %0d cycles with %0d results never arrived",
               cyc, exp_res.size());
      $display("errors: mismatch=%0d other=%0d", mism, other + 1);
      $display("TEST FAIL");
      $finish;
    end
  end

  // Outputs checked mid-cycle
  always @(negedge clk) begin
    if (rst_n) begin
      check_illegal(illegal, ill_exp);
      check_busy(busy, q_cnt >= UOP_DEPTH - 1);
      if (result_valid) begin
        if (exp_res.size() == 0) begin
          $display("%0t: result for rd %0d arrived with nothing outstanding",
                   $time, result_rd);
          other++;
        end else begin
          e_res  = exp_res.pop_front();
          e_rd   = exp_rd.pop_front();
          e_zero = exp_zero.pop_front();
          e_cyc  = exp_cyc.pop_front();
          check_result(result, result_rd, result_zero, e_res, e_rd, e_zero);
          if (e_cyc >= 0 && last_hold_cyc <= e_cyc) begin
            check_latency(cyc - e_cyc, 3);
          end
        end
      end
    end
  end

  initial begin
    rst_n   = 1'b0;
    issue   = 1'b0;
    insn    = '0;
    rs1_val = '0;
    rs2_val = '0;
    hold    = 1'b0;
    for (int i = 0; i < MAX_REC*WORDS; i++) begin
      vec[i] = '0;
    end
    $readmemh("testbench/alu_exec_tests.txt", vec);
    // A zero instruction word ends the list
    while (n_rec < MAX_REC && vec[n_rec*WORDS] != '0) begin
      hold_sum += int'(vec[n_rec*WORDS+3]);
      n_rec++;
    end
    limit = n_rec * 8 + hold_sum + 50;

    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    while (idx < n_rec || exp_res.size() != 0 || hold_left > 0) begin
      @(posedge clk);
      if (hold_left > 0) begin
        hold_left--;
      end
      // busy seen here lags a cycle, so a legal issue last cycle blocks this one
      if (idx < n_rec && !busy && !(issue && !ill_drv)) begin
        issue_record(idx);
        idx++;
      end else begin
        issue   <= 1'b0;
        ill_drv <= 1'b0;
      end
      hold <= (hold_left > 0);
    end
    // Let the last illegal and result checks settle
    repeat (3) @(posedge clk);

    $display("errors: mismatch=%0d other=%0d", mism, other);
    if (mism == 0 && other == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- testbench/alu_exec_tests.txt
// insn     rs1      rs2      hold  result   illegal
// one record per line, all hex, a zero insn ends the list
002081B3 FFFF0010 00000123 0 FFFF0133 0
40208233 FFFF0010 00000123 8 FFFEFEED 0
002092B3 FFFF0010 00000123 0 FFF80080 0
0020A333 FFFF0010 00000123 0 00000001 0
0020B3B3 FFFF0010 00000123 0 00000000 0
0020C433 FFFF0010 00000123 0 FFFF0133 0
0020D4B3 FFFF0010 00000123 0 1FFFE002 0
4020D533 FFFF0010 00000123 0 FFFFE002 0
0020E5B3 FFFF0010 00000123 0 FFFF0133 0
0020F633 FFFF0010 00000123 0 00000000 0
402086B3 12345678 12345678 0 00000000 0
0020A733 FFFFFFFE FFFFFFFF 0 00000001 0
0020B1B3 00000001 80000000 0 00000001 0
0020A233 00000001 80000000 0 00000000 0
123452B7 00000000 00000000 0 00000000 1
022081B3 11111111 22222222 0 00000000 1
002082B3 7FFFFFFF 00000001 0 80000000 0
4020F633 11111111 22222222 0 00000000 1
40409513 11111111 22222222 0 00000000 1
FFF08293 00000010 DEADBEEF 3 0000000F 0
8000F313 1234ABCD DEADBEEF 0 1234A800 0
7FF0C393 0000F0F0 DEADBEEF 0 0000F70F 0
FFB0A413 FFFFFFF0 DEADBEEF 0 00000001 0
FFF0B493 00000005 DEADBEEF 5 00000001 0
00409513 0000ABCD DEADBEEF 0 000ABCD0 0
4080D593 80001234 DEADBEEF 0 FF800012 0
01F0D613 80000000 DEADBEEF 0 00000001 0
0000E693 00000000 DEADBEEF 0 00000000 0
00000000 00000000 00000000 0 00000000 0

//--- verilog/alu.sv
`timescale 1ns/1ps

module alu (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     hold,
  alu_uop_if.consumer              uop,
  output logic                     result_valid,
  output logic [alu_pkg::XLEN-1:0] result,
  output alu_pkg::reg_idx_t        result_rd,
  output logic                     result_zero
);
  import alu_pkg::*;

  // All candidate results, computed in parallel
  logic [XLEN-1:0] and_res;
  logic [XLEN-1:0] or_res;
  logic [XLEN-1:0] xor_res;
  logic [XLEN-1:0] sll_res;
  logic [XLEN-1:0] srl_res;
  logic [XLEN-1:0] sra_res;
  logic [XLEN-1:0] add_res;
  logic [XLEN-1:0] sub_res;
  logic            slt_res;
  logic            sltu_res;

  logic [XLEN-1:0] b_inv;
  logic            sub_cout;
  logic [4:0]      shamt;
  logic [XLEN-1:0] sel_res;
  logic            pop;

  // Pop whenever a micro-op waits and no stall
  assign pop      = uop.valid & ~hold;
  assign uop.take = pop;

  // Shift amount is the low five bits of b
  assign shamt = uop.b[4:0];

  assign and_res = uop.a & uop.b;
  assign or_res  = uop.a | uop.b;
  assign xor_res = uop.a ^ uop.b;
  assign sll_res = uop.a << shamt;
  assign srl_res = uop.a >> shamt;
  assign sra_res = $unsigned($signed(uop.a) >>> shamt);
  assign add_res = uop.a + uop.b;

  // a - b as a + ~b + 1, carry kept for the unsigned compare
  assign b_inv = ~uop.b;
  assign {sub_cout, sub_res} = {1'b0, uop.a} + {1'b0, b_inv} + {{XLEN{1'b0}}, 1'b1};

  // No borrow out means a >= b unsigned
  assign sltu_res = ~sub_cout;

  // Signs differ: the negative one is smaller
  // Signs equal: the difference cannot overflow, use its sign
  assign slt_res = (uop.a[XLEN-1] ^ uop.b[XLEN-1]) ? uop.a[XLEN-1] : sub_res[XLEN-1];

  // Result select, unused codes read as zero
  always_comb begin
    case (uop.op)
      ALU_AND:  sel_res = and_res;
      ALU_OR:   sel_res = or_res;
      ALU_XOR:  sel_res = xor_res;
      ALU_SLL:  sel_res = sll_res;
      ALU_SRL:  sel_res = srl_res;
      ALU_SRA:  sel_res = sra_res;
      ALU_ADD:  sel_res = add_res;
      ALU_SUB:  sel_res = sub_res;
      ALU_SLT:  sel_res = {{(XLEN-1){1'b0}}, slt_res};
      ALU_SLTU: sel_res = {{(XLEN-1){1'b0}}, sltu_res};
      default:  sel_res = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= pop;
    end
  end

  // Output payload, loaded only on a pop
  always_ff @(posedge clk) begin
    if (pop) begin
      result      <= sel_res;
      result_rd   <= uop.rd;
      result_zero <= ~(|sel_res);
    end
  end

endmodule

//--- verilog/alu_exec_top.sv
`timescale 1ns/1ps

module alu_exec_top (
  input  logic                     clk,
  input  logic                     rst_n,
  // Issue side
  input  logic                     issue,
  input  alu_pkg::insn_t           insn,
  input  logic [alu_pkg::XLEN-1:0] rs1_val,
  input  logic [alu_pkg::XLEN-1:0] rs2_val,
  output logic                     busy,
  output logic                     illegal,
  // Stall from downstream
  input  logic                     hold,
  // Result side
  output logic                     result_valid,
  output logic [alu_pkg::XLEN-1:0] result,
  output alu_pkg::reg_idx_t        result_rd,
  output logic                     result_zero
);

  // Decoder to queue, valid is a push strobe
  alu_uop_if dec_uop ();

  // Queue head to ALU, take pops
  alu_uop_if q_uop ();

  insn_decoder u_decoder (
    .clk     (clk),
    .rst_n   (rst_n),
    .issue   (issue),
    .insn    (insn),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .illegal (illegal),
    .uop     (dec_uop.producer)
  );

  uop_fifo u_queue (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr      (dec_uop.consumer),
    .rd_side (q_uop.producer),
    .busy    (busy)
  );

  // Issue to result is 3 cycles through an empty queue
  alu u_alu (
    .clk          (clk),
    .rst_n        (rst_n),
    .hold         (hold),
    .uop          (q_uop.consumer),
    .result_valid (result_valid),
    .result       (result),
    .result_rd    (result_rd),
    .result_zero  (result_zero)
  );

endmodule

//--- verilog/alu_pkg.sv
package alu_pkg;

  // Data path width
  localparam int XLEN = 32;

  // Micro-op queue sizing
  localparam int UOP_DEPTH = 4;
  localparam int UOP_PTR_W = $clog2(UOP_DEPTH);
  localparam int UOP_CNT_W = $clog2(UOP_DEPTH + 1);

  // RV32I major opcodes handled by this stage
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  // funct3 field values
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // funct7 values, ALT selects SUB and SRA
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // Register index
  typedef logic [4:0] reg_idx_t;

  // ALU operation codes, gaps in the code space give zero
  typedef enum logic [3:0] {
    ALU_AND  = 4'b0001,
    ALU_OR   = 4'b0010,
    ALU_XOR  = 4'b0011,
    ALU_SLL  = 4'b0101,
    ALU_SRL  = 4'b0110,
    ALU_SRA  = 4'b0111,
    ALU_ADD  = 4'b1000,
    ALU_SUB  = 4'b1100,
    ALU_SLT  = 4'b1101,
    ALU_SLTU = 4'b1111
  } alu_op_t;

  // One instruction word, R-type or I-type view
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      reg_idx_t   rs2;
      reg_idx_t   rs1;
      logic [2:0] funct3;
      reg_idx_t   rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm;
      reg_idx_t    rs1;
      logic [2:0]  funct3;
      reg_idx_t    rd;
      logic [6:0]  opcode;
    } i;
  } insn_t;

endpackage

//--- verilog/alu_uop_if.sv
`timescale 1ns/1ps

interface alu_uop_if;
  import alu_pkg::*;

  // Micro-op payload and its qualifier
  logic             valid;
  alu_op_t          op;
  logic [XLEN-1:0]  a;
  logic [XLEN-1:0]  b;
  reg_idx_t         rd;

  // Pop strobe from the receiving side
  logic             take;

  // Sending side
  modport producer (
    output valid, op, a, b, rd,
    input  take
  );

  // Receiving side
  modport consumer (
    input  valid, op, a, b, rd,
    output take
  );

endinterface

//--- verilog/insn_decoder.sv
`timescale 1ns/1ps

module insn_decoder (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     issue,
  input  alu_pkg::insn_t           insn,
  input  logic [alu_pkg::XLEN-1:0] rs1_val,
  input  logic [alu_pkg::XLEN-1:0] rs2_val,
  output logic                     illegal,
  alu_uop_if.producer              uop
);
  import alu_pkg::*;

  alu_op_t         dec_op;
  logic [XLEN-1:0] dec_b;
  logic            dec_ok;

  // funct3 to ALU code, alt picks SUB or SRA
  function automatic alu_op_t map_op(input logic [2:0] funct3, input logic alt);
    alu_op_t op;
    op = ALU_ADD;
    case (funct3)
      F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
      F3_SLL:  op = ALU_SLL;
      F3_SLT:  op = ALU_SLT;
      F3_SLTU: op = ALU_SLTU;
      F3_XOR:  op = ALU_XOR;
      F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:   op = ALU_OR;
      F3_AND:  op = ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    dec_ok = 1'b0;
    dec_op = ALU_ADD;
    dec_b  = rs2_val;
    case (insn.r.opcode)
      OPC_OP: begin
        // Bit 30 of the word selects the alternate op
        dec_op = map_op(insn.r.funct3, insn.r.funct7[5]);
        if (insn.r.funct7 == F7_BASE) begin
          dec_ok = 1'b1;
        end else if (insn.r.funct7 == F7_ALT) begin
          // Only SUB and SRA have an alternate form
          dec_ok = (insn.r.funct3 == F3_ADD) || (insn.r.funct3 == F3_SR);
        end
      end
      OPC_OP_IMM: begin
        if (insn.i.funct3 == F3_SLL) begin
          // SLLI takes shamt from imm[4:0]
          dec_op = ALU_SLL;
          dec_b  = {{(XLEN-5){1'b0}}, insn.i.imm[4:0]};
          dec_ok = (insn.i.imm[11:5] == F7_BASE);
        end else if (insn.i.funct3 == F3_SR) begin
          // SRLI or SRAI by imm[10]
          dec_op = map_op(F3_SR, insn.i.imm[10]);
          dec_b  = {{(XLEN-5){1'b0}}, insn.i.imm[4:0]};
          dec_ok = (insn.i.imm[11:5] == F7_BASE) || (insn.i.imm[11:5] == F7_ALT);
        end else begin
          // Sign-extended immediate, never a subtract
          dec_op = map_op(insn.i.funct3, 1'b0);
          dec_b  = {{(XLEN-12){insn.i.imm[11]}}, insn.i.imm};
          dec_ok = 1'b1;
        end
      end
      default: dec_ok = 1'b0;
    endcase
  end

  // One-cycle push or illegal pulse per issue
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      uop.valid <= 1'b0;
      illegal   <= 1'b0;
    end else begin
      uop.valid <= issue & dec_ok;
      illegal   <= issue & ~dec_ok;
    end
  end

  // Payload, qualified by valid downstream
  always_ff @(posedge clk) begin
    if (issue) begin
      uop.op <= dec_op;
      uop.a  <= rs1_val;
      uop.b  <= dec_b;
      uop.rd <= insn.r.rd;
    end
  end

endmodule

//--- verilog/uop_fifo.sv
`timescale 1ns/1ps

module uop_fifo (
  input  logic         clk,
  input  logic         rst_n,
  alu_uop_if.consumer  wr,
  alu_uop_if.producer  rd_side,
  output logic         busy
);
  import alu_pkg::*;

  // Storage, one array per field
  alu_op_t         op_mem [UOP_DEPTH];
  logic [XLEN-1:0] a_mem  [UOP_DEPTH];
  logic [XLEN-1:0] b_mem  [UOP_DEPTH];
  reg_idx_t        rd_mem [UOP_DEPTH];

  logic [UOP_PTR_W-1:0] wr_ptr;
  logic [UOP_PTR_W-1:0] rd_ptr;
  logic [UOP_CNT_W-1:0] count;
  logic                 push;
  logic                 pop;

  // Issuer keeps the queue from overflowing, so every push is accepted
  assign push    = wr.valid;
  assign wr.take = push;
  // ALU takes only a valid head
  assign pop     = rd_side.take;

  // Show-ahead head entry
  assign rd_side.valid = (count != '0);
  assign rd_side.op    = op_mem[rd_ptr];
  assign rd_side.a     = a_mem[rd_ptr];
  assign rd_side.b     = b_mem[rd_ptr];
  assign rd_side.rd    = rd_mem[rd_ptr];

  // Headroom for the micro-op still in the decoder register
  assign busy = (count >= UOP_CNT_W'(UOP_DEPTH - 1));

  always_ff @(posedge clk) begin
    if (push) begin
      op_mem[wr_ptr] <= wr.op;
      a_mem[wr_ptr]  <= wr.a;
      b_mem[wr_ptr]  <= wr.b;
      rd_mem[wr_ptr] <= wr.rd;
    end
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule
